//--- src.f
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
tests/rv_clock_gen.sv
tests/rv_checker.sv
tests/rv_tb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module rv_tb -f src.f --Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vrv_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "RESULT: PASS" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- tests/rv_tb.sv
`default_nettype none

module rv_tb;

    localparam int clk_period    = 20;
    localparam int rst_cycles    = 16;
    localparam int drive_delay   = 2;
    localparam int n_instr       = 600;
    // average is well under two cycles per instruction
    localparam int watchdog_time = (n_instr * 4 + rst_cycles) * clk_period;

    typedef struct packed {
        rv_pkg::res_t rpt;
        logic [31:0]  due;  // cycle count when the report shows
    } exp_t;

    logic                          clk;
    logic                          rst;
    logic                          instr_valid;
    rv_pkg::instr_u                instr;
    logic                          wb_valid;
    logic                          wb_write;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]       wb_data;

    logic [31:0] lfsr_state = 32'h5ff6_6c71;
    logic [31:0] cycle = '0;
    logic [31:0] model_regs [32];
    exp_t        exp_q [$];
    int          next_idx = 0;
    logic        passed = 1'b0;
    logic        failed = 1'b0;

    rv_clock_gen #(
        .period     (clk_period),
        .rst_cycles (rst_cycles),
        .rst_delay  (drive_delay)
    ) u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    rv_core i_dut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_wb_valid    (wb_valid),
        .o_wb_write    (wb_write),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data)
    );

    // ----------------------------------------------
    // stimulus and reference model
    // ----------------------------------------------
    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_alu(
        input logic [2:0]  f3,
        input logic        sub,
        input logic        arith,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (arith) begin
                    return $unsigned($signed(a) >>> sh);
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic issue_instr();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] uimm;
        logic [31:0] word;
        logic [31:0] res;
        logic        wr;
        exp_t        e;
        kind = 4'(take_bits(4));
        f3   = 3'(take_bits(3));
        alt  = 1'(take_bits(1));
        rd   = 5'(take_bits(2)); // x0..x3 only
        rs1  = 5'(take_bits(2));
        rs2  = 5'(take_bits(2));
        imm  = 12'(take_bits(12));
        uimm = 20'(take_bits(20));
        wr   = (rd != 5'd0);
        if (kind < 4'd6) begin
            word = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
                    rv_pkg::opc_op};
            res  = ref_alu(f3, word[30], word[30], model_regs[rs1], model_regs[rs2]);
        end else if (kind < 4'd12) begin
            if (f3 == 3'd1) begin
                imm[11:5] = 7'b0;
            end else if (f3 == 3'd5) begin
                imm[11:5] = {1'b0, alt, 5'b0}; // srli or srai
            end
            word = {imm, rs1, f3, rd, rv_pkg::opc_op_imm};
            res  = ref_alu(f3, 1'b0, word[30], model_regs[rs1], {{20{imm[11]}}, imm});
        end else if (kind < 4'd14) begin
            word = {uimm, rd, rv_pkg::opc_lui};
            res  = {uimm, 12'b0};
        end else begin
            // load and branch, not handled by the core
            word = {imm, rs1, f3, rd, kind[0] ? 7'b0000011 : 7'b1100011};
            res  = '0;
            wr   = 1'b0;
        end
        if (wr) begin
            model_regs[rd] = res;
        end
        e.rpt.valid = 1'b1;
        e.rpt.write = wr;
        e.rpt.rd    = rd;
        e.rpt.data  = res;
        e.due       = cycle + 32'd2;
        exp_q.push_back(e);
        instr       = word;
        instr_valid = 1'b1;
    endtask

    // ----------------------------------------------
    // checking
    // ----------------------------------------------
    task automatic stop_with_failure();
        failed = 1'b1;
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_field(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (expected == actual) else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) cycle <= cycle + 32'd1;

    always @(negedge clk) begin : monitor
        exp_t e;
        if (rst) begin
            assert (!wb_valid) else begin
                $display("writeback report seen while reset is asserted");
                stop_with_failure();
            end
        end else if (wb_valid) begin
            assert (next_idx < exp_q.size()) else begin
                $display("writeback report with no instruction outstanding");
                stop_with_failure();
            end
            e = exp_q[next_idx];
            next_idx++;
            check_field("report cycle", e.due, cycle);
            check_field("report write", 32'(e.rpt.write), 32'(wb_write));
            check_field("report rd", 32'(e.rpt.rd), 32'(wb_rd));
            check_field("report data", e.rpt.data, wb_data);
        end else begin
            assert (next_idx >= exp_q.size() || exp_q[next_idx].due != cycle) else begin
                $display("expected writeback report missing at cycle %0d", cycle);
                stop_with_failure();
            end
        end
    end

    initial begin : driver
        int issued;
        instr_valid = 1'b0;
        instr       = '0;
        issued      = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        // strobes while reset is held must never reach the outputs
        repeat (rst_cycles - 4) begin
            @(posedge clk);
            #(drive_delay);
            instr_valid = 1'b1;
            instr       = take_bits(32);
        end
        @(posedge clk);
        #(drive_delay);
        instr_valid = 1'b0;
        @(negedge rst);
        while (issued < n_instr) begin
            @(posedge clk);
            #(drive_delay);
            if (2'(take_bits(2)) == 2'd0) begin
                instr_valid = 1'b0;
                instr       = take_bits(32); // junk word on an idle cycle
            end else begin
                issue_instr();
                issued++;
            end
        end
        @(posedge clk);
        #(drive_delay);
        instr_valid = 1'b0;
        repeat (4) @(posedge clk);
        if (next_idx == exp_q.size()) begin
            passed = 1'b1;
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("%0d writeback reports never appeared", exp_q.size() - next_idx);
            stop_with_failure();
        end
    end

    initial begin : watchdog
        #(watchdog_time);
        $display("watchdog expired after %0d time units", watchdog_time);
        stop_with_failure();
    end

    final begin
        if (!passed && !failed) begin
            $display("run ended without a pass verdict");
            $display("RESULT: FAIL");
        end
    end

endmodule

`default_nettype wire

//--- tests/rv_checker.sv
`default_nettype none

module rv_checker (
    input wire logic                          i_clk,
    input wire logic                          i_rst,
    input wire logic                          i_instr_valid,
    input wire logic                          i_wb_valid,
    input wire logic                          i_wb_write,
    input wire logic [rv_pkg::reg_addr_w-1:0] i_wb_rd
);

    // ----------------------------------------------
    // writeback report shape
    // ----------------------------------------------
    a_write_has_valid: assert property (
        @(posedge i_clk) disable iff (i_rst) i_wb_write |-> i_wb_valid
    ) else $error("write flagged on a report that is not valid");

    a_write_not_x0: assert property (
        @(posedge i_clk) disable iff (i_rst) i_wb_write |-> (i_wb_rd != '0)
    ) else $error("write flagged with rd equal to x0");

    // two stage registers between the strobe and the report
    a_report_latency: assert property (
        @(posedge i_clk) disable iff (i_rst) i_wb_valid == $past(i_instr_valid, 2)
    ) else $error("report valid does not follow instruction valid by two cycles");

endmodule

bind rv_core rv_checker u_checker (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_instr_valid (i_instr_valid),
    .i_wb_valid    (o_wb_valid),
    .i_wb_write    (o_wb_write),
    .i_wb_rd       (o_wb_rd)
);

`default_nettype wire

//--- tests/rv_clock_gen.sv
`default_nettype none

module rv_clock_gen #(
    parameter int period     = 20,
    parameter int rst_cycles = 16,
    parameter int rst_delay  = 2
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(period / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (rst_cycles) @(posedge o_clk);
        #(rst_delay) o_rst = 1'b0; // released just after an edge
    end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`default_nettype none

module rv_core (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_instr_valid,
    input  wire rv_pkg::instr_u                 i_instr,
    output logic                                o_wb_valid,
    output logic                                o_wb_write,
    output logic      [rv_pkg::reg_addr_w-1:0]  o_wb_rd,
    output logic      [rv_pkg::xlen-1:0]        o_wb_data
);

    logic [rv_pkg::reg_addr_w-1:0] w_rs1_addr;
    logic [rv_pkg::reg_addr_w-1:0] w_rs2_addr;
    logic [rv_pkg::xlen-1:0]       w_rs1_data;
    logic [rv_pkg::xlen-1:0]       w_rs2_data;
    rv_pkg::dec_t                  w_dec;
    rv_pkg::res_t                  w_fwd;
    rv_pkg::res_t                  w_res;

    rv_decode u_decode (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_fwd         (w_fwd),
        .i_res         (w_res),
        .i_rs1_data    (w_rs1_data),
        .i_rs2_data    (w_rs2_data),
        .o_rs1_addr    (w_rs1_addr),
        .o_rs2_addr    (w_rs2_addr),
        .o_dec         (w_dec)
    );

    rv_execute u_execute (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_dec (w_dec),
        .o_fwd (w_fwd),
        .o_res (w_res)
    );

    rv_writeback u_writeback (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_res      (w_res),
        .i_rs1_addr (w_rs1_addr),
        .i_rs2_addr (w_rs2_addr),
        .o_rs1_data (w_rs1_data),
        .o_rs2_data (w_rs2_data)
    );

    // report straight from the execute register
    assign o_wb_valid = w_res.valid;
    assign o_wb_write = w_res.write;
    assign o_wb_rd    = w_res.rd;
    assign o_wb_data  = w_res.data;

endmodule

`default_nettype wire

//--- verilog/rv_writeback.sv
`default_nettype none

module rv_writeback (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire rv_pkg::res_t                   i_res,
    input  wire logic [rv_pkg::reg_addr_w-1:0]  i_rs1_addr,
    input  wire logic [rv_pkg::reg_addr_w-1:0]  i_rs2_addr,
    output logic      [rv_pkg::xlen-1:0]        o_rs1_data,
    output logic      [rv_pkg::xlen-1:0]        o_rs2_data
);

    localparam int n_regs = 1 << rv_pkg::reg_addr_w;

    // x0 has no storage
    logic [rv_pkg::xlen-1:0] r_regs [1:n_regs-1];
    logic                    w_we;

    assign w_we = i_res.valid && i_res.write && (i_res.rd != '0);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 1; i < n_regs; i++) begin
                r_regs[i] <= '0;
            end
        end else if (w_we) begin
            r_regs[i_res.rd] <= i_res.data;
        end
    end

    // ----------------------------------------------
    // read ports, combinational
    // ----------------------------------------------
    always_comb begin
        if (i_rs1_addr == '0) begin
            o_rs1_data = '0;
        end else begin
            o_rs1_data = r_regs[i_rs1_addr];
        end
    end

    always_comb begin
        if (i_rs2_addr == '0) begin
            o_rs2_data = '0;
        end else begin
            o_rs2_data = r_regs[i_rs2_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_execute.sv
`default_nettype none

module rv_execute (
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    input  wire rv_pkg::dec_t i_dec,
    output rv_pkg::res_t      o_fwd,
    output rv_pkg::res_t      o_res
);

    logic [$clog2(rv_pkg::xlen)-1:0] w_shamt;
    logic                            w_lt_s;
    logic                            w_lt_u;
    logic [rv_pkg::xlen-1:0]         w_result;
    rv_pkg::res_t                    r_res;

    assign w_shamt = i_dec.op_b[$clog2(rv_pkg::xlen)-1:0]; // low 5 bits only
    assign w_lt_s  = $signed(i_dec.op_a) < $signed(i_dec.op_b);
    assign w_lt_u  = i_dec.op_a < i_dec.op_b;

    // ----------------------------------------------
    // ALU
    // ----------------------------------------------
    always_comb begin
        case (i_dec.op)
            rv_pkg::alu_add: begin
                w_result = i_dec.op_a + i_dec.op_b;
            end
            rv_pkg::alu_sub: begin
                w_result = i_dec.op_a - i_dec.op_b;
            end
            rv_pkg::alu_sll: begin
                w_result = i_dec.op_a << w_shamt;
            end
            rv_pkg::alu_slt: begin
                w_result = {{(rv_pkg::xlen-1){1'b0}}, w_lt_s};
            end
            rv_pkg::alu_sltu: begin
                w_result = {{(rv_pkg::xlen-1){1'b0}}, w_lt_u};
            end
            rv_pkg::alu_xor: begin
                w_result = i_dec.op_a ^ i_dec.op_b;
            end
            rv_pkg::alu_srl: begin
                w_result = i_dec.op_a >> w_shamt;
            end
            rv_pkg::alu_sra: begin
                w_result = $unsigned($signed(i_dec.op_a) >>> w_shamt);
            end
            rv_pkg::alu_or: begin
                w_result = i_dec.op_a | i_dec.op_b;
            end
            rv_pkg::alu_and: begin
                w_result = i_dec.op_a & i_dec.op_b;
            end
            rv_pkg::alu_pass_b: begin
                w_result = i_dec.op_b; // lui, op_a is zero
            end
            default: begin
                w_result = '0;
            end
        endcase
    end

    // ----------------------------------------------
    // result, live and registered
    // ----------------------------------------------
    always_comb begin
        o_fwd       = '0;
        o_fwd.valid = i_dec.valid;
        o_fwd.write = i_dec.write;
        o_fwd.rd    = i_dec.rd;
        o_fwd.data  = w_result;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_res <= '0;
        end else begin
            r_res <= o_fwd;
        end
    end

    assign o_res = r_res; // also the writeback report

endmodule

`default_nettype wire

//--- verilog/rv_decode.sv
`default_nettype none

module rv_decode (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_instr_valid,
    input  wire rv_pkg::instr_u                 i_instr,
    input  wire rv_pkg::res_t                   i_fwd,
    input  wire rv_pkg::res_t                   i_res,
    input  wire logic [rv_pkg::xlen-1:0]        i_rs1_data,
    input  wire logic [rv_pkg::xlen-1:0]        i_rs2_data,
    output logic      [rv_pkg::reg_addr_w-1:0]  o_rs1_addr,
    output logic      [rv_pkg::reg_addr_w-1:0]  o_rs2_addr,
    output rv_pkg::dec_t                        o_dec
);

    rv_pkg::alu_op_e            w_op;
    logic                       w_supported;
    logic                       w_use_imm;
    logic                       w_is_lui;
    logic [rv_pkg::xlen-1:0]    w_imm_i;
    logic [rv_pkg::xlen-1:0]    w_imm_u;
    logic [rv_pkg::xlen-1:0]    w_rs1_val;
    logic [rv_pkg::xlen-1:0]    w_rs2_val;
    rv_pkg::dec_t               w_dec;
    rv_pkg::dec_t               r_dec;

    // funct3 plus funct7 bit 5 to an ALU op; sub only exists for OP
    function automatic rv_pkg::alu_op_e f3_to_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        rv_pkg::alu_op_e op;
        op = rv_pkg::alu_add;
        case (f3)
            rv_pkg::f3_add:  op = (alt && is_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:  op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:  op = rv_pkg::alu_slt;
            rv_pkg::f3_sltu: op = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:  op = rv_pkg::alu_xor;
            rv_pkg::f3_sr:   op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:   op = rv_pkg::alu_or;
            rv_pkg::f3_and:  op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    // youngest result wins, then registered result, then the file
    function automatic logic [rv_pkg::xlen-1:0] fwd_pick(
        input logic [rv_pkg::reg_addr_w-1:0] addr,
        input rv_pkg::res_t                  fwd,
        input rv_pkg::res_t                  res,
        input logic [rv_pkg::xlen-1:0]       file_data
    );
        logic [rv_pkg::xlen-1:0] val;
        val = file_data;
        if (fwd.valid && fwd.write && fwd.rd == addr) begin
            val = fwd.data;
        end else if (res.valid && res.write && res.rd == addr) begin
            val = res.data;
        end
        return val;
    endfunction

    // ----------------------------------------------
    // register reads and immediates
    // ----------------------------------------------
    assign o_rs1_addr = i_instr.rtype.rs1;
    assign o_rs2_addr = i_instr.rtype.rs2;

    assign w_imm_i = {{(rv_pkg::xlen-12){i_instr.itype.imm[11]}}, i_instr.itype.imm};
    assign w_imm_u = {i_instr.itype.imm, i_instr.itype.rs1, i_instr.itype.funct3,
                      {(rv_pkg::instr_w-20){1'b0}}};

    assign w_rs1_val = fwd_pick(o_rs1_addr, i_fwd, i_res, i_rs1_data);
    assign w_rs2_val = fwd_pick(o_rs2_addr, i_fwd, i_res, i_rs2_data);

    // ----------------------------------------------
    // opcode decode
    // ----------------------------------------------
    always_comb begin
        w_op        = rv_pkg::alu_add;
        w_supported = 1'b0;
        w_use_imm   = 1'b0;
        w_is_lui    = 1'b0;
        case (i_instr.rtype.opcode)
            rv_pkg::opc_op: begin
                w_supported = 1'b1;
                w_op = f3_to_op(i_instr.rtype.funct3, i_instr.rtype.funct7[5], 1'b1);
            end
            rv_pkg::opc_op_imm: begin
                w_supported = 1'b1;
                w_use_imm   = 1'b1;
                // funct7 bit 5 sits at imm[10], picks srai
                w_op = f3_to_op(i_instr.rtype.funct3, i_instr.rtype.funct7[5], 1'b0);
            end
            rv_pkg::opc_lui: begin
                w_supported = 1'b1;
                w_is_lui    = 1'b1;
                w_op        = rv_pkg::alu_pass_b;
            end
            default: ; // unsupported, reports with no write
        endcase
    end

    always_comb begin
        w_dec       = '0;
        w_dec.valid = i_instr_valid;
        w_dec.rd    = i_instr.rtype.rd;
        if (w_supported) begin
            w_dec.write = i_instr_valid && (i_instr.rtype.rd != '0);
            w_dec.op    = w_op;
            w_dec.op_a  = w_is_lui ? '0 : w_rs1_val;
            if (w_is_lui) begin
                w_dec.op_b = w_imm_u;
            end else begin
                w_dec.op_b = w_use_imm ? w_imm_i : w_rs2_val;
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_dec <= '0;
        end else begin
            r_dec <= w_dec;
        end
    end

    assign o_dec = r_dec;

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ----------------------------------------------
    // widths
    // ----------------------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int instr_w    = 32;

    // ----------------------------------------------
    // encodings
    // ----------------------------------------------
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    localparam logic [2:0] f3_add  = 3'b000; // add/sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101; // srl/sra by funct7 bit 5
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui
    } alu_op_e;

    // ----------------------------------------------
    // instruction word layouts
    // ----------------------------------------------
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fields_t;

    // U-type immediate is {imm, rs1, funct3} of this layout
    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t rtype;
        i_fields_t itype;
    } instr_u;

    // ----------------------------------------------
    // stage records
    // ----------------------------------------------
    typedef struct packed {
        logic                  valid;
        logic                  write;  // supported and rd != x0
        logic [reg_addr_w-1:0] rd;
        alu_op_e               op;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
    } dec_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } res_t;

endpackage

`default_nettype wire
